/* project.f */
rtl/dcache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_arbiter.sv
rtl/miss_unit.sv
rtl/writeback_buffer.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := dcache_tb
FILELIST  := project.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* dv/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int N_LINES     = 16;
    localparam int WB_DEPTH    = 4;
    localparam int INDEX_BITS  = $clog2(N_LINES);
    localparam int SPACE       = 512;   // bytes reached by the stimulus
    localparam int N_RANDOM    = 180;
    localparam int CYCLE_LIMIT = 200 * 40 + N_LINES * 20 + 8;

    logic      clock;
    logic      reset;
    logic      request_valid;
    logic      request_write;
    mem_size_t request_size;
    addr_t     request_addr;
    word_t     request_wdata;
    logic      stall;
    logic      response_valid;
    word_t     response_data;
    bus_cmd_t  mem_command;
    addr_t     mem_addr;
    line_t     mem_wdata;
    mem_tag_t  mem_response;
    line_t     mem_data;
    mem_tag_t  mem_tag;
    logic      done;
    logic      flush_finished;

    logic [7:0]  shadow     [SPACE];
    logic        written    [SPACE];
    logic        line_valid [N_LINES];   // expected cache contents, tag per index
    addr_t       line_tag   [N_LINES];
    logic [31:0] rng;
    int          cycle_count;
    int          waiting;                // accepted requests still without a response

    dcache_top #(.N_LINES(N_LINES), .WB_DEPTH(WB_DEPTH)) dut0 (.*);

    mem_model mem0 (.*);

    always #10 clock = ~clock;

    task automatic flag_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [7:0] initial_byte(input int b);
        logic [31:0] a;
        logic [31:0] w;
        a = b & ~3;
        w = (a * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
        return w[8 * (b % 4) +: 8];
    endfunction

    function automatic int size_bytes(input mem_size_t size);
        return (size == MEM_BYTE) ? 1 : ((size == MEM_HALF) ? 2 : 4);
    endfunction

    // little endian, zero extended to a word
    function automatic word_t expected_load(input addr_t addr, input mem_size_t size);
        word_t r;
        r = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            r[8 * k +: 8] = shadow[int'(addr) + k];
        end
        return r;
    endfunction

    task automatic run_access(input logic write, input mem_size_t size, input addr_t addr,
                              input word_t wdata);
        int    latency;
        int    idx;
        logic  expect_hit;
        word_t expected;
        idx        = int'(addr[BLOCK_OFFSET_BITS +: INDEX_BITS]);
        expect_hit = line_valid[idx] && line_tag[idx] == addr >> (BLOCK_OFFSET_BITS + INDEX_BITS);
        expected   = expected_load(addr, size);
        request_valid = 1'b1;
        request_write = write;
        request_size  = size;
        request_addr  = addr;
        request_wdata = wdata;
        @(negedge clock);
        while (stall) @(negedge clock);
        @(posedge clock);               // accepted here
        #2;
        request_valid = 1'b0;
        latency = 0;
        do begin
            @(negedge clock);
            latency++;
        end while (!response_valid);
        assert (expect_hit ? latency == 1 : latency > 1)
            else flag_mismatch($sformatf("access at %h answered after %0d cycles, hit %0b",
                                         addr, latency, expect_hit));
        assert (!stall)
            else flag_mismatch($sformatf("stall still high with the response for %h", addr));
        if (!write) begin
            assert (response_data == expected)
                else flag_mismatch($sformatf("%0s load at %h returned %h, expected %h",
                                             size.name(), addr, response_data, expected));
        end else begin
            for (int k = 0; k < size_bytes(size); k++) begin
                shadow[int'(addr) + k]  = wdata[8 * k +: 8];
                written[int'(addr) + k] = 1'b1;
            end
        end
        line_valid[idx] = 1'b1;         // write-allocate, so every access brings its line in
        line_tag[idx]   = addr >> (BLOCK_OFFSET_BITS + INDEX_BITS);
        @(posedge clock);
        #2;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            cycle_count <= 0;
            waiting     <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            waiting     <= waiting + int'(request_valid && !stall) - int'(response_valid);
            if (cycle_count == CYCLE_LIMIT) abort_run("timeout, the run did not complete");
        end
    end

    a_reset_idle: assert property (@(posedge clock)
        $fell(reset) |-> !stall && !response_valid && mem_command == BUS_NONE && !flush_finished)
        else abort_run("DUT outputs not idle after reset");

    a_one_response: assert property (@(posedge clock) disable iff (reset)
        response_valid |-> waiting == 1)
        else abort_run("response_valid without a matching accepted request");

    a_finished_holds: assert property (@(posedge clock) disable iff (reset)
        flush_finished |=> flush_finished)
        else abort_run("flush_finished fell before reset");

    a_flush_stalls: assert property (@(posedge clock) disable iff (reset)
        flush_finished |-> stall)
        else abort_run("stall went low after the flush");

    initial begin
        addr_t     addr;
        mem_size_t size;
        logic      write_op;
        clock         = 1'b0;
        reset         = 1'b1;
        request_valid = 1'b0;
        request_write = 1'b0;
        request_size  = MEM_BYTE;
        request_addr  = '0;
        request_wdata = '0;
        done          = 1'b0;
        rng           = 32'hdd79_2aae;
        for (int b = 0; b < SPACE; b++) begin
            shadow[b]  = initial_byte(b);
            written[b] = 1'b0;
        end
        for (int i = 0; i < N_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;

        // untouched memory, then hits in the same line
        run_access(1'b0, MEM_WORD, 32'h0000_0040, '0);
        run_access(1'b0, MEM_BYTE, 32'h0000_0043, '0);
        run_access(1'b0, MEM_HALF, 32'h0000_0046, '0);
        // stores of each size merged into one line
        run_access(1'b1, MEM_WORD, 32'h0000_0100, 32'h1122_3344);
        run_access(1'b1, MEM_BYTE, 32'h0000_0101, 32'h0000_00ab);
        run_access(1'b1, MEM_HALF, 32'h0000_0106, 32'h0000_beef);
        run_access(1'b0, MEM_WORD, 32'h0000_0100, '0);
        run_access(1'b0, MEM_WORD, 32'h0000_0104, '0);
        run_access(1'b0, MEM_BYTE, 32'h0000_0105, '0);
        // 0x018 and 0x098 share index 3, so the dirty line is evicted
        run_access(1'b1, MEM_WORD, 32'h0000_0018, 32'hcafe_f00d);
        run_access(1'b0, MEM_WORD, 32'h0000_0098, '0);
        run_access(1'b0, MEM_WORD, 32'h0000_0018, '0);
        run_access(1'b0, MEM_HALF, 32'h0000_001a, '0);

        for (int n = 0; n < N_RANDOM; n++) begin
            rng      = xorshift32(rng);
            size     = (rng[11:10] == 2'd0) ? MEM_BYTE
                     : ((rng[11:10] == 2'd1) ? MEM_HALF : MEM_WORD);
            addr     = addr_t'(rng[8:0]);
            write_op = rng[12];
            if (size == MEM_HALF) addr[0] = 1'b0;
            if (size == MEM_WORD) addr[1:0] = 2'b00;
            rng = xorshift32(rng);
            run_access(write_op, size, addr, rng);
        end

        done = 1'b1;
        while (!flush_finished) @(negedge clock);
        repeat (3) @(negedge clock);    // flush_finished must hold, with stall high
        for (int b = 0; b < SPACE; b++) begin
            if (written[b]) begin
                assert (mem0.storage[b / 8][8 * (b % 8) +: 8] == shadow[b])
                    else flag_mismatch($sformatf("memory byte %h holds %h, expected %h", b,
                                                 mem0.storage[b / 8][8 * (b % 8) +: 8],
                                                 shadow[b]));
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* dv/mem_model.sv */
`timescale 1ns/10ps

module mem_model
    import dcache_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int LATENCY = 6,
    parameter int LINES   = 128
) (
    input  logic     clock,
    input  logic     reset,
    input  bus_cmd_t mem_command,
    input  addr_t    mem_addr,
    input  line_t    mem_wdata,
    output mem_tag_t mem_response,
    output line_t    mem_data,
    output mem_tag_t mem_tag
);

    localparam int INDEX_BITS = $clog2(LINES);

    line_t       storage   [LINES];
    mem_tag_t    tag_pipe  [LATENCY];   // load answers in flight, oldest at the end
    line_t       data_pipe [LATENCY];
    mem_tag_t    next_tag;
    logic        refuse;
    logic [31:0] rng;
    logic        accept;
    logic [INDEX_BITS-1:0] line_index;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // every word starts as a hash of its byte address
    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        for (int i = 0; i < LINES; i++) begin
            storage[i] = {pattern_word(8 * i + 4), pattern_word(8 * i)};
        end
    end

    assign line_index   = mem_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign accept       = mem_command != BUS_NONE && !refuse;
    assign mem_response = accept ? next_tag : '0;
    assign mem_tag      = tag_pipe[LATENCY-1];
    assign mem_data     = data_pipe[LATENCY-1];

    always @(posedge clock) begin
        if (reset) begin
            rng      <= 32'hdd79_2aae;
            refuse   <= 1'b0;
            next_tag <= 4'd1;
            for (int i = 0; i < LATENCY; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            rng    <= xorshift32(rng);
            refuse <= !refuse && rng[1:0] == 2'b00;   // never two refusals in a row
            for (int i = LATENCY - 1; i > 0; i--) begin
                tag_pipe[i]  <= tag_pipe[i-1];
                data_pipe[i] <= data_pipe[i-1];
            end
            tag_pipe[0]  <= (accept && mem_command == BUS_LOAD) ? next_tag : '0;
            data_pipe[0] <= storage[line_index];     // read at acceptance
            if (accept) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;   // zero is reserved
                if (mem_command == BUS_STORE) storage[line_index] <= mem_wdata;
            end
        end
    end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int N_LINES  = 16,
    parameter int WB_DEPTH = 4
) (
    input  logic      clock,
    input  logic      reset,
    // processor side
    input  logic      request_valid,
    input  logic      request_write,
    input  mem_size_t request_size,
    input  addr_t     request_addr,
    input  word_t     request_wdata,
    output logic      stall,
    output logic      response_valid,
    output word_t     response_data,
    // memory side
    output bus_cmd_t  mem_command,
    output addr_t     mem_addr,
    output line_t     mem_wdata,
    input  mem_tag_t  mem_response,
    input  line_t     mem_data,
    input  mem_tag_t  mem_tag,
    // end of program
    input  logic      done,
    output logic      flush_finished
);

    addr_t     array_addr;
    logic      store_enable;
    mem_size_t store_size;
    word_t     store_data;
    logic      fill_enable;
    line_t     fill_data;
    logic [$clog2(N_LINES)-1:0] flush_index;
    logic      flush_clean;
    logic      hit;
    word_t     read_word;
    logic      victim_dirty;
    addr_t     victim_addr;
    line_t     victim_line;

    logic      miss_start;
    addr_t     miss_addr;
    logic      fill_ready;
    line_t     fill_line;

    logic      wb_push;
    addr_t     wb_push_addr;
    line_t     wb_push_line;
    logic      wb_take;
    logic      wb_full;
    logic      wb_empty;
    logic      wb_match;
    line_t     wb_line;

    logic      write_request;
    addr_t     write_addr;
    line_t     write_line;
    logic      read_request;
    addr_t     read_addr;
    logic      write_grant;
    logic      read_grant;
    mem_tag_t  bus_response;

    dcache_ctrl #(.N_LINES(N_LINES)) ctrl0 (.*);

    dcache_array #(.N_LINES(N_LINES)) array0 (.*);

    miss_unit miss0 (
        .clock        (clock),
        .reset        (reset),
        .miss_start   (miss_start),
        .miss_addr    (miss_addr),
        .grant        (read_grant),
        .bus_response (bus_response),
        .mem_tag      (mem_tag),
        .mem_data     (mem_data),
        .read_request (read_request),
        .read_addr    (read_addr),
        .fill_ready   (fill_ready),
        .fill_line    (fill_line)
    );

    writeback_buffer #(.WB_DEPTH(WB_DEPTH)) wb0 (
        .clock         (clock),
        .reset         (reset),
        .wb_push       (wb_push),
        .wb_push_addr  (wb_push_addr),
        .wb_push_line  (wb_push_line),
        .lookup_addr   (miss_addr),    // the miss asks the buffer first
        .wb_take       (wb_take),
        .grant         (write_grant),
        .bus_response  (bus_response),
        .wb_full       (wb_full),
        .wb_empty      (wb_empty),
        .wb_match      (wb_match),
        .wb_line       (wb_line),
        .write_request (write_request),
        .write_addr    (write_addr),
        .write_line    (write_line)
    );

    mem_arbiter arb0 (.*);

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int N_LINES = 16
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      request_valid,
    input  logic      request_write,
    input  mem_size_t request_size,
    input  addr_t     request_addr,
    input  word_t     request_wdata,
    input  logic      done,
    input  logic      hit,
    input  word_t     read_word,
    input  logic      victim_dirty,
    input  addr_t     victim_addr,
    input  line_t     victim_line,
    input  logic      fill_ready,
    input  line_t     fill_line,
    input  logic      wb_full,
    input  logic      wb_empty,
    input  logic      wb_match,
    input  line_t     wb_line,
    output logic      stall,
    output logic      response_valid,
    output word_t     response_data,
    output logic      flush_finished,
    output addr_t     array_addr,
    output logic      store_enable,
    output mem_size_t store_size,
    output word_t     store_data,
    output logic      fill_enable,
    output line_t     fill_data,
    output logic [$clog2(N_LINES)-1:0] flush_index,
    output logic      flush_clean,
    output logic      miss_start,
    output addr_t     miss_addr,
    output logic      wb_push,
    output addr_t     wb_push_addr,
    output line_t     wb_push_line,
    output logic      wb_take
);

    localparam int INDEX_BITS = $clog2(N_LINES);
    typedef logic [INDEX_BITS-1:0] index_t;

    typedef enum logic [1:0] {
        S_READY,
        S_MISS,
        S_FILL,
        S_FLUSH
    } state_t;

    state_t    state;
    state_t    next_state;
    addr_t     req_addr;    // request held across a miss
    logic      req_write;
    mem_size_t req_size;
    word_t     req_wdata;
    line_t     fill_buf;    // line from memory or from the write-back buffer
    logic      miss_sent;
    logic      walk_done;
    index_t    flush_ptr;
    logic      fill_go;
    logic      flush_step;
    logic      hit_accept;

    assign stall        = state != S_READY;
    assign hit_accept   = state == S_READY && request_valid && hit;
    assign miss_addr    = {req_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
    assign fill_data    = fill_buf;
    assign flush_index  = flush_ptr;
    assign wb_push_addr = victim_addr;
    assign wb_push_line = victim_line;

    // a dirty victim must fit in the buffer before the slot can be reused
    assign fill_go     = state == S_FILL && !(victim_dirty && wb_full);
    assign flush_step  = state == S_FLUSH && !walk_done && !(victim_dirty && wb_full);
    assign fill_enable = fill_go;
    assign flush_clean = flush_step && victim_dirty;
    assign wb_push     = (fill_go || flush_step) && victim_dirty;
    assign wb_take     = state == S_MISS && !miss_sent && wb_match;   // forward from buffer
    assign miss_start  = state == S_MISS && !miss_sent && !wb_match;

    always_comb begin
        array_addr   = req_addr;
        store_size   = req_size;
        store_data   = req_wdata;
        store_enable = fill_go && req_write;    // merge a pending store into the fill
        case (state)
            S_READY: begin
                array_addr   = request_addr;
                store_size   = request_size;
                store_data   = request_wdata;
                store_enable = request_valid && request_write && hit;
            end
            S_FLUSH: array_addr = addr_t'({flush_ptr, {BLOCK_OFFSET_BITS{1'b0}}});
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            S_READY: begin
                if (request_valid && !hit) begin
                    next_state = S_MISS;
                end else if (!request_valid && done) begin
                    next_state = S_FLUSH;
                end
            end
            S_MISS: begin
                if (wb_take || (miss_sent && fill_ready)) begin
                    next_state = S_FILL;
                end
            end
            S_FILL:  if (fill_go) next_state = S_READY;
            default: ;      // flush never leaves
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= S_READY;
            response_valid <= 1'b0;
            miss_sent      <= 1'b0;
            walk_done      <= 1'b0;
            flush_ptr      <= '0;
            flush_finished <= 1'b0;
        end else begin
            state          <= next_state;
            response_valid <= hit_accept || fill_go;
            if (miss_start) begin
                miss_sent <= 1'b1;
            end else if (state == S_FILL) begin
                miss_sent <= 1'b0;
            end
            if (flush_step) begin
                if (flush_ptr == index_t'(N_LINES - 1)) begin
                    walk_done <= 1'b1;
                end else begin
                    flush_ptr <= flush_ptr + 1'b1;
                end
            end
            if (walk_done && wb_empty) flush_finished <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_READY && request_valid && !hit) begin
            req_addr  <= request_addr;
            req_write <= request_write;
            req_size  <= request_size;
            req_wdata <= request_wdata;
        end
        if (wb_take) begin
            fill_buf <= wb_line;
        end else if (state == S_MISS && fill_ready) begin
            fill_buf <= fill_line;
        end
        response_data <= read_word;     // qualified by response_valid
    end

endmodule

/* rtl/dcache_array.sv */
`timescale 1ns/10ps

module dcache_array
    import dcache_pkg::*;
#(
    parameter int N_LINES = 16
) (
    input  logic      clock,
    input  logic      reset,
    input  addr_t     array_addr,
    input  logic      store_enable,
    input  mem_size_t store_size,
    input  word_t     store_data,
    input  logic      fill_enable,
    input  line_t     fill_data,
    input  logic [$clog2(N_LINES)-1:0] flush_index,
    input  logic      flush_clean,
    output logic      hit,
    output word_t     read_word,
    output logic      victim_dirty,
    output addr_t     victim_addr,
    output line_t     victim_line
);

    localparam int INDEX_BITS = $clog2(N_LINES);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - BLOCK_OFFSET_BITS;

    typedef logic [INDEX_BITS-1:0]        index_t;
    typedef logic [TAG_BITS-1:0]          tag_t;
    typedef logic [BLOCK_OFFSET_BITS-1:0] offset_t;

    logic [N_LINES-1:0] valid;
    logic [N_LINES-1:0] dirty;
    tag_t               tags  [N_LINES];
    line_t              lines [N_LINES];

    tag_t    req_tag;
    index_t  index;
    offset_t offset;
    line_t   base_line;     // stored line, or the incoming fill
    line_t   merged_line;

    assign req_tag = array_addr[ADDR_BITS-1 -: TAG_BITS];
    assign index   = array_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
    assign offset  = array_addr[BLOCK_OFFSET_BITS-1:0];

    assign hit          = valid[index] && tags[index] == req_tag;
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_addr  = {tags[index], index, offset_t'(0)};
    assign victim_line  = lines[index];
    assign base_line    = fill_enable ? fill_data : lines[index];

    // extract the load data and build the store merge, both zero extended by size
    always_comb begin
        read_word   = '0;
        merged_line = base_line;
        case (store_size)
            MEM_BYTE: begin
                read_word[7:0]               = base_line[8 * offset +: 8];
                merged_line[8 * offset +: 8] = store_data[7:0];
            end
            MEM_HALF: begin
                read_word[15:0] = base_line[16 * offset[BLOCK_OFFSET_BITS-1:1] +: 16];
                merged_line[16 * offset[BLOCK_OFFSET_BITS-1:1] +: 16] = store_data[15:0];
            end
            default: begin
                read_word = base_line[32 * offset[BLOCK_OFFSET_BITS-1:2] +: 32];
                merged_line[32 * offset[BLOCK_OFFSET_BITS-1:2] +: 32] = store_data;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (fill_enable) begin
                valid[index] <= 1'b1;
                dirty[index] <= store_enable;   // write miss leaves the line dirty
            end else if (store_enable) begin
                dirty[index] <= 1'b1;
            end
            if (flush_clean) dirty[flush_index] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_enable) tags[index] <= req_tag;
        if (fill_enable || store_enable) begin
            lines[index] <= store_enable ? merged_line : base_line;
        end
    end

endmodule

/* rtl/writeback_buffer.sv */
`timescale 1ns/10ps

module writeback_buffer
    import dcache_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int WB_DEPTH = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wb_push,
    input  addr_t    wb_push_addr,
    input  line_t    wb_push_line,
    input  addr_t    lookup_addr,
    input  logic     wb_take,
    input  logic     grant,
    input  mem_tag_t bus_response,
    output logic     wb_full,
    output logic     wb_empty,
    output logic     wb_match,
    output line_t    wb_line,
    output logic     write_request,
    output addr_t    write_addr,
    output line_t    write_line
);

    localparam int PTR_BITS = $clog2(WB_DEPTH);

    typedef logic [PTR_BITS-1:0]                    slot_t;
    typedef logic [ADDR_BITS-BLOCK_OFFSET_BITS-1:0] line_addr_t;

    logic [WB_DEPTH-1:0] valid;
    line_addr_t          addrs [WB_DEPTH];
    line_t               lines [WB_DEPTH];
    logic [PTR_BITS:0]   head;
    logic [PTR_BITS:0]   tail;
    logic [PTR_BITS:0]   used;      // slots in order, holes from forwarding included
    slot_t               head_slot;
    slot_t               tail_slot;
    slot_t               match_slot;
    logic                drained;

    assign used      = tail - head;
    assign head_slot = head[PTR_BITS-1:0];
    assign tail_slot = tail[PTR_BITS-1:0];
    assign wb_full   = used == (PTR_BITS + 1)'(WB_DEPTH);
    assign wb_empty  = valid == '0;

    // oldest entry goes to the bus, a store is done once accepted
    assign write_request = valid[head_slot];
    assign write_addr    = {addrs[head_slot], {BLOCK_OFFSET_BITS{1'b0}}};
    assign write_line    = lines[head_slot];
    assign drained       = write_request && grant && bus_response != '0;

    always_comb begin
        wb_match   = 1'b0;
        match_slot = '0;
        for (int i = 0; i < WB_DEPTH; i++) begin
            if (valid[i] && addrs[i] == lookup_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS]) begin
                wb_match   = 1'b1;
                match_slot = slot_t'(i);
            end
        end
    end

    assign wb_line = lines[match_slot];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (wb_push) begin
                valid[tail_slot] <= 1'b1;
                tail             <= tail + 1'b1;
            end
            if (wb_take) valid[match_slot] <= 1'b0;
            if (drained) valid[head_slot] <= 1'b0;
            // skip over entries taken for forwarding
            if (used != '0 && (drained || !valid[head_slot])) head <= head + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wb_push) begin
            addrs[tail_slot] <= wb_push_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS];
            lines[tail_slot] <= wb_push_line;
        end
    end

    a_no_push_full: assert property (
        @(posedge clock) disable iff (reset) wb_push |-> !wb_full
    );

endmodule

/* rtl/miss_unit.sv */
`timescale 1ns/10ps

module miss_unit
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     miss_start,
    input  addr_t    miss_addr,
    input  logic     grant,
    input  mem_tag_t bus_response,
    input  mem_tag_t mem_tag,
    input  line_t    mem_data,
    output logic     read_request,
    output addr_t    read_addr,
    output logic     fill_ready,
    output line_t    fill_line
);

    logic     pending;      // waiting for the bus to accept
    logic     outstanding;  // accepted, waiting for the data
    mem_tag_t wait_tag;
    addr_t    line_addr;

    assign read_request = pending;
    assign read_addr    = line_addr;
    assign fill_ready   = outstanding && mem_tag != '0 && mem_tag == wait_tag;
    assign fill_line    = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending     <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (miss_start) begin
                pending <= 1'b1;
            end else if (pending && grant && bus_response != '0) begin
                pending     <= 1'b0;
                outstanding <= 1'b1;
            end
            if (fill_ready) outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (miss_start) line_addr <= miss_addr;
        if (pending && grant && bus_response != '0) wait_tag <= bus_response;
    end

    a_one_read: assert property (
        @(posedge clock) disable iff (reset) miss_start |-> !pending && !outstanding
    );

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     write_request,
    input  addr_t    write_addr,
    input  line_t    write_line,
    input  logic     read_request,
    input  addr_t    read_addr,
    input  mem_tag_t mem_response,
    output logic     write_grant,
    output logic     read_grant,
    output mem_tag_t bus_response,
    output bus_cmd_t mem_command,
    output addr_t    mem_addr,
    output line_t    mem_wdata
);

    // write-backs first, so evicted lines leave the buffer quickly
    assign write_grant  = write_request;
    assign read_grant   = read_request && !write_request;
    assign bus_response = (write_grant || read_grant) ? mem_response : '0;

    assign mem_command = write_grant ? BUS_STORE : (read_grant ? BUS_LOAD : BUS_NONE);
    assign mem_addr    = write_grant ? write_addr : read_addr;
    assign mem_wdata   = write_line;        // ignored by the bus on a load

endmodule

/* rtl/mem_bus_pkg.sv */
package mem_bus_pkg;

    // command on the split-transaction memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_t;

    // zero means no response, or command refused
    typedef logic [3:0] mem_tag_t;

endpackage

/* rtl/dcache_pkg.sv */
package dcache_pkg;

    // geometry shared by the cache and its line buffers
    localparam int ADDR_BITS         = 32;
    localparam int BLOCK_OFFSET_BITS = 3;   // 8 bytes per line

    typedef logic [ADDR_BITS-1:0] addr_t;   // byte address
    typedef logic [31:0]          word_t;   // processor load/store data
    typedef logic [63:0]          line_t;   // one cache block, same as bus data

    // access size of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

endpackage
